//--- Makefile
# Verilator build and run of the POST supervision testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_hmc_post_top
FILELIST  := files.f
OBJDIR    := obj_dir

SRCS := $(wildcard *.sv *.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)

//--- files.f
+incdir+.
hmc_post_pkg.sv
flit_stream_if.sv
link_reset_sequencer.sv
post_flit_counter.sv
post_result_latch.sv
link_source_select.sv
hmc_post_top.sv
tb_hmc_post_top.sv

//--- flit_stream_if.sv
// One transmit flit stream, valid/ready style
// A flit moves on a rising edge with valid and ready both high
// valid never waits for ready; no clock is carried here
`timescale 1ns/1ps
`default_nettype none

`include "hmc_post_defines.svh"

interface flit_stream_if
  import hmc_post_pkg::*;
  ();

  logic       valid;  // Flit on data/mask is valid
  logic       ready;  // Sink accepts this cycle
  flit_t      data;   // Payload
  byte_mask_t mask;   // Byte enables for data

  // ------------------------------
  // Producer side
  // ------------------------------
  modport source (
    output valid,
    output data,
    output mask,
    input  ready
  );

  // Consumer side, owns ready
  modport sink (
    input  valid,
    input  data,
    input  mask,
    output ready
  );

endinterface

`default_nettype wire

//--- hmc_post_defines.svh
// Sizes and thresholds for the two-link POST supervision logic
// Thresholds are scaled down for simulation; raise the bit positions
// for hardware (about bit 25 for POST and bit 30 for timeout)
// HMC_POST_DONE_BIT must stay below HMC_CNT_W
`ifndef HMC_POST_DEFINES_SVH
`define HMC_POST_DEFINES_SVH

// ------------------------------
// Link and datapath sizes
// ------------------------------
`define HMC_NUM_LINKS      2    // Supervised links
`define HMC_FLIT_W         256  // One transmit flit payload
`define HMC_MASK_W         32   // One mask bit per payload byte
`define HMC_CNT_W          16   // Rx flit and error counters

// ------------------------------
// Timing thresholds as bit positions
// ------------------------------
// POST done once this flit counter bit is set (2^5 = 32 flits)
`define HMC_POST_DONE_BIT  5

// Watchdog bit that starts a retry after 2^8 cycles
`define HMC_TIMEOUT_BIT    8

// Retry reset lasts 2^3 + 1 cycles
`define HMC_RETRY_BIT      3

`endif

//--- hmc_post_pkg.sv
// Shared types for the POST supervision logic
// Widths come from the defines header, so edit sizes there only
`default_nettype none

`include "hmc_post_defines.svh"

package hmc_post_pkg;

  // ------------------------------
  // Transmit stream payload
  // ------------------------------
  // One flit as handed to the link core
  typedef logic [`HMC_FLIT_W-1:0] flit_t;

  // Byte enables, bit n covers data byte n
  typedef logic [`HMC_MASK_W-1:0] byte_mask_t;

  // ------------------------------
  // Per-link status
  // ------------------------------
  // One bit per link, bit 0 is the first link
  typedef logic [`HMC_NUM_LINKS-1:0] link_vec_t;

  // Rx flit and error counts, saturating
  typedef logic [`HMC_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

//--- hmc_post_top.sv
// POST supervision for two memory links
// Rx flits arrive as valid/error strobes from an external checker
// All per-link ports are indexed by link, bit or element 0 first
// Transmit streams are plain valid/ready, the core accepts on ready
`timescale 1ns/1ps
`default_nettype none

`include "hmc_post_defines.svh"

module hmc_post_top
  import hmc_post_pkg::*;
(
  input  wire                                    USER_CLK,
  input  wire                                    USER_RST,
  input  wire link_vec_t                         qpll_lock,       // PLL locked
  input  wire link_vec_t                         link_init_done,  // Link core up
  input  wire link_vec_t                         rx_valid,        // Rx flit strobe
  input  wire link_vec_t                         rx_error,        // Rx flit bad
  // POST flit source
  input  wire link_vec_t                         post_tx_valid,
  input  wire flit_t      [`HMC_NUM_LINKS-1:0]   post_tx_data,
  input  wire byte_mask_t [`HMC_NUM_LINKS-1:0]   post_tx_mask,
  // User flit source
  input  wire link_vec_t                         user_tx_valid,
  input  wire flit_t      [`HMC_NUM_LINKS-1:0]   user_tx_data,
  input  wire byte_mask_t [`HMC_NUM_LINKS-1:0]   user_tx_mask,
  input  wire link_vec_t                         core_tx_ready,
  // Status
  output wire link_vec_t                         link_soft_reset,
  output wire                                    retry_active,
  output wire                                    init_done,
  output wire                                    post_ok,
  // To the link cores
  output wire link_vec_t                         core_tx_valid,
  output wire flit_t      [`HMC_NUM_LINKS-1:0]   core_tx_data,
  output wire byte_mask_t [`HMC_NUM_LINKS-1:0]   core_tx_mask,
  output wire link_vec_t                         post_tx_ready,
  output wire link_vec_t                         user_tx_ready
);

  cnt_t [`HMC_NUM_LINKS-1:0] flit_cnt;  // Counter to verdict
  cnt_t [`HMC_NUM_LINKS-1:0] err_cnt;

  // ------------------------------
  // Reset and watchdog
  // ------------------------------
  link_reset_sequencer u_seq (
    .USER_CLK        (USER_CLK),
    .USER_RST        (USER_RST),
    .qpll_lock       (qpll_lock),
    .link_init_done  (link_init_done),
    .link_soft_reset (link_soft_reset),
    .retry_active    (retry_active)
  );

  // POST verdict over both links
  post_result_latch u_result (
    .USER_CLK  (USER_CLK),
    .USER_RST  (USER_RST),
    .flit_cnt  (flit_cnt),
    .err_cnt   (err_cnt),
    .init_done (init_done),
    .post_ok   (post_ok)
  );

  // ------------------------------
  // Per-link counters and stream select
  // ------------------------------
  for (genvar i = 0; i < `HMC_NUM_LINKS; i++) begin : g_link
    flit_stream_if post_if ();
    flit_stream_if user_if ();
    flit_stream_if core_if ();

    post_flit_counter u_cnt (
      .USER_CLK        (USER_CLK),
      .link_soft_reset (link_soft_reset[i]),
      .link_init_done  (link_init_done[i]),
      .rx_valid        (rx_valid[i]),
      .rx_error        (rx_error[i]),
      .flit_cnt        (flit_cnt[i]),
      .err_cnt         (err_cnt[i])
    );

    // Plain ports onto the streams
    assign post_if.valid    = post_tx_valid[i];
    assign post_if.data     = post_tx_data[i];
    assign post_if.mask     = post_tx_mask[i];
    assign post_tx_ready[i] = post_if.ready;
    assign user_if.valid    = user_tx_valid[i];
    assign user_if.data     = user_tx_data[i];
    assign user_if.mask     = user_tx_mask[i];
    assign user_tx_ready[i] = user_if.ready;
    assign core_if.ready    = core_tx_ready[i];
    assign core_tx_valid[i] = core_if.valid;
    assign core_tx_data[i]  = core_if.data;
    assign core_tx_mask[i]  = core_if.mask;

    link_source_select u_sel (
      .init_done (init_done),
      .post      (post_if),
      .user      (user_if),
      .core      (core_if)
    );
  end

endmodule

`default_nettype wire

//--- link_reset_sequencer.sv
// Watchdog and soft reset generation for all links
// A retry fires if not every link reports init done within
// 2^HMC_TIMEOUT_BIT cycles; the watchdog restarts when the retry begins
// qpll_lock and link_init_done must already be in the USER_CLK domain
`timescale 1ns/1ps
`default_nettype none

`include "hmc_post_defines.svh"

module link_reset_sequencer
  import hmc_post_pkg::*;
(
  input  wire       USER_CLK,
  input  wire       USER_RST,         // Async, active high
  input  wire       link_vec_t qpll_lock,
  input  wire       link_vec_t link_init_done,
  output link_vec_t link_soft_reset,  // Combinational, per link
  output logic      retry_active      // Timed retry reset in progress
);

  localparam int WD_W = `HMC_TIMEOUT_BIT + 1;  // Top bit is the timeout flag
  localparam int RT_W = `HMC_RETRY_BIT + 1;    // Top bit ends the retry

  logic [WD_W-1:0] wd_cnt;       // Watchdog
  logic [RT_W-1:0] retry_cnt;    // Retry length
  logic            retry_start;  // Timeout seen, retry begins next edge
  logic            all_up;       // Every link finished init

  assign all_up      = &link_init_done;
  assign retry_start = wd_cnt[WD_W-1] & ~retry_active;

  // ------------------------------
  // Soft reset per link
  // ------------------------------
  // Any of: global reset, lost PLL lock, retry window
  assign link_soft_reset = {`HMC_NUM_LINKS{USER_RST}}
                         | ~qpll_lock
                         | {`HMC_NUM_LINKS{retry_active}};

  // ------------------------------
  // Watchdog
  // ------------------------------
  always_ff @(posedge USER_CLK or posedge USER_RST) begin
    if (USER_RST) begin
      wd_cnt <= '0;
    end else if (all_up || retry_start) begin
      wd_cnt <= '0;  // Links up, or retry restarts the wait
    end else begin
      wd_cnt <= wd_cnt + WD_W'(1);
    end
  end

  // ------------------------------
  // Retry window
  // ------------------------------
  // High for 2^HMC_RETRY_BIT + 1 cycles from the edge after timeout
  always_ff @(posedge USER_CLK or posedge USER_RST) begin
    if (USER_RST) begin
      retry_active <= 1'b0;
      retry_cnt    <= '0;
    end else if (retry_start) begin
      retry_active <= 1'b1;
      retry_cnt    <= '0;
    end else if (retry_active) begin
      if (retry_cnt[RT_W-1]) begin
        retry_active <= 1'b0;  // Length reached
        retry_cnt    <= '0;
      end else begin
        retry_cnt <= retry_cnt + RT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- link_source_select.sv
// Transmit source select for one link
// POST source drives the core until init_done, the user source after
// Purely combinational; no buffering, both sources see the core's ready
`timescale 1ns/1ps
`default_nettype none

`include "hmc_post_defines.svh"

module link_source_select
  import hmc_post_pkg::*;
(
  input  wire           init_done,  // Switch to user source
  flit_stream_if.sink   post,       // POST flit source
  flit_stream_if.sink   user,       // User flit source
  flit_stream_if.source core        // Link core transmit port
);

  // ------------------------------
  // Forward path
  // ------------------------------
  always_comb begin
    if (init_done) begin
      core.valid = user.valid;
      core.data  = user.data;
      core.mask  = user.mask;
    end else begin
      core.valid = post.valid;  // Still in POST
      core.data  = post.data;
      core.mask  = post.mask;
    end
  end

  // ------------------------------
  // Return path
  // ------------------------------
  // Idle source ignores ready since its valid is not forwarded
  assign post.ready = core.ready;
  assign user.ready = core.ready;

endmodule

`default_nettype wire

//--- post_flit_counter.sv
// Rx flit and error counters for one link during POST
// Strobes come from an external flit checker, one per received flit
// Counts saturate at all ones and clear while the link soft reset is high
`timescale 1ns/1ps
`default_nettype none

`include "hmc_post_defines.svh"

module post_flit_counter
  import hmc_post_pkg::*;
(
  input  wire  USER_CLK,
  input  wire  link_soft_reset,  // Async clear, active high
  input  wire  link_init_done,   // Link up, counting enabled
  input  wire  rx_valid,         // One received flit
  input  wire  rx_error,         // That flit failed its check
  output cnt_t flit_cnt,         // Flits seen while up
  output cnt_t err_cnt           // Failed flits seen while up
);

  logic count_en;  // Qualified flit strobe

  // Increment unless already at the top
  function automatic cnt_t sat_inc(input cnt_t cnt);
    cnt_t next;
    next = cnt;
    if (cnt != '1) begin
      next = cnt + cnt_t'(1);
    end
    return next;
  endfunction

  assign count_en = link_init_done & rx_valid;

  // ------------------------------
  // Counters
  // ------------------------------
  always_ff @(posedge USER_CLK or posedge link_soft_reset) begin
    if (link_soft_reset) begin
      flit_cnt <= '0;
      err_cnt  <= '0;
    end else if (count_en) begin
      flit_cnt <= sat_inc(flit_cnt);
      if (rx_error) begin
        err_cnt <= sat_inc(err_cnt);  // Error flits also count as flits
      end
    end
  end

endmodule

`default_nettype wire

//--- post_result_latch.sv
// POST verdict across all links
// init_done and post_ok stay set until USER_RST; a retry does not clear them
// post_ok only sets on a clean rising edge of the pass condition
`timescale 1ns/1ps
`default_nettype none

`include "hmc_post_defines.svh"

module post_result_latch
  import hmc_post_pkg::*;
(
  input  wire  USER_CLK,
  input  wire  USER_RST,                            // Async active high reset
  input  wire  cnt_t [`HMC_NUM_LINKS-1:0] flit_cnt,  // Per link
  input  wire  cnt_t [`HMC_NUM_LINKS-1:0] err_cnt,   // Per link
  output logic init_done,
  output logic post_ok
);

  logic       done;        // Every link saw enough flits
  logic       errs_clear;  // No link saw a bad flit
  logic       ok;          // Registered done and error free
  logic [1:0] ok_hist;     // Two-stage history of ok

  // ------------------------------
  // Verdict
  // ------------------------------
  always_comb begin
    done       = 1'b1;
    errs_clear = 1'b1;
    for (int i = 0; i < `HMC_NUM_LINKS; i++) begin
      done       = done & flit_cnt[i][`HMC_POST_DONE_BIT];
      errs_clear = errs_clear & (err_cnt[i] == '0);
    end
  end

  // ------------------------------
  // Sticky outputs
  // ------------------------------
  always_ff @(posedge USER_CLK or posedge USER_RST) begin
    if (USER_RST) begin
      init_done <= 1'b0;
      post_ok   <= 1'b0;
      ok        <= 1'b0;
      ok_hist   <= 2'b00;
    end else begin
      ok      <= done & errs_clear;
      ok_hist <= {ok_hist[0], ok};
      if (done) begin
        init_done <= 1'b1;  // One cycle after done
      end
      if (ok_hist == 2'b01) begin
        post_ok <= 1'b1;    // Rising edge of ok seen 3 cycles late
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_hmc_post_top.sv
// Self-checking testbench for the two-link POST supervision top level
// Each table row starts from a fresh USER_RST because the results are sticky
// A row with zero flits holds link_init_done low and checks the watchdog retry
// Rx strobes stand in for the external flit checker
`timescale 1ns/1ps
`default_nettype none

`include "hmc_post_defines.svh"

module tb_hmc_post_top
  import hmc_post_pkg::*;
();

  localparam int NL            = `HMC_NUM_LINKS;
  localparam int RESET_CYCLES  = 16;
  localparam int TIMEOUT_EDGES = (1 << `HMC_TIMEOUT_BIT) + 1;  // Release to retry
  localparam int RETRY_CYCLES  = (1 << `HMC_RETRY_BIT) + 1;    // Retry width
  localparam int POST_FLITS    = 1 << `HMC_POST_DONE_BIT;
  localparam int INIT_LATENCY  = 2;  // Last counted flit to init_done
  localparam int OK_LATENCY    = 4;  // Last counted flit to post_ok

  typedef struct {
    string     name;
    int        nflits;        // Flits per link where 0 runs the retry check
    int        err_idx [NL];  // Flagged flit per link or -1 for none
    link_vec_t lock;          // qpll_lock during the test
    link_vec_t ready;         // core_tx_ready during the test
    logic      exp_init;
    logic      exp_ok;
  } test_row_t;

  logic                  USER_CLK;
  logic                  USER_RST;
  link_vec_t             qpll_lock;
  link_vec_t             link_init_done;
  link_vec_t             rx_valid;
  link_vec_t             rx_error;
  link_vec_t             post_tx_valid;
  flit_t      [NL-1:0]   post_tx_data;
  byte_mask_t [NL-1:0]   post_tx_mask;
  link_vec_t             user_tx_valid;
  flit_t      [NL-1:0]   user_tx_data;
  byte_mask_t [NL-1:0]   user_tx_mask;
  link_vec_t             core_tx_ready;
  link_vec_t             link_soft_reset;
  logic                  retry_active;
  logic                  init_done;
  logic                  post_ok;
  link_vec_t             core_tx_valid;
  flit_t      [NL-1:0]   core_tx_data;
  byte_mask_t [NL-1:0]   core_tx_mask;
  link_vec_t             post_tx_ready;
  link_vec_t             user_tx_ready;

  test_row_t   rows [$];
  logic [31:0] rng_state;
  string       cur_name;
  int          test_errors;
  int          passed;
  int          failed;
  int          cycles;
  int          cycle_limit;

  hmc_post_top dut0 (.*);

  // ------------------------------
  // Clock and run limit
  // ------------------------------
  initial USER_CLK = 1'b0;
  always #10 USER_CLK = ~USER_CLK;  // 20 ns period

  always @(posedge USER_CLK) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: simulation ran past %0d cycles without finishing", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  // LCG with 32-bit state
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  function automatic flit_t rand_flit();
    flit_t f;
    for (int w = 0; w < `HMC_FLIT_W / 32; w++) begin
      f[w*32 +: 32] = next_rand();
    end
    return f;
  endfunction

  task automatic add_row(input string name, input int nflits, input int err0, input int err1,
                         input link_vec_t lock, input link_vec_t ready,
                         input logic exp_init, input logic exp_ok);
    test_row_t r;
    r.name       = name;
    r.nflits     = nflits;
    r.err_idx[0] = err0;
    r.err_idx[1] = err1;
    r.lock       = lock;
    r.ready      = ready;
    r.exp_init   = exp_init;
    r.exp_ok     = exp_ok;
    rows.push_back(r);
  endtask

  // New payload on both sources right after a rising edge
  task automatic drive_payload();
    link_vec_t v;
    v = link_vec_t'(next_rand());
    post_tx_valid <= v;
    user_tx_valid <= ~v;  // Opposite of post so a wrong select shows
    for (int i = 0; i < NL; i++) begin
      post_tx_data[i] <= rand_flit();
      post_tx_mask[i] <= byte_mask_t'(next_rand());
      user_tx_data[i] <= rand_flit();
      user_tx_mask[i] <= byte_mask_t'(next_rand());
    end
  endtask

  // ------------------------------
  // Checking helpers
  // ------------------------------
  task automatic log_mismatch(input string what, input flit_t exp, input flit_t act);
    $display("** Error %s: %s expected %0h actual %0h", cur_name, what, exp, act);
    test_errors++;
  endtask

  task automatic log_failure(input string msg);
    $display("Test %s: %s", cur_name, msg);
    test_errors++;
  endtask

  // Core side must mirror the expected source; ready goes back to both
  task automatic check_stream(input logic use_user);
    logic       exp_valid;
    flit_t      exp_data;
    byte_mask_t exp_mask;
    for (int i = 0; i < NL; i++) begin
      exp_valid = use_user ? user_tx_valid[i] : post_tx_valid[i];
      exp_data  = use_user ? user_tx_data[i] : post_tx_data[i];
      exp_mask  = use_user ? user_tx_mask[i] : post_tx_mask[i];
      if (core_tx_valid[i] !== exp_valid) begin
        log_mismatch($sformatf("core_tx_valid[%0d]", i), flit_t'(exp_valid),
                     flit_t'(core_tx_valid[i]));
      end
      if (core_tx_data[i] !== exp_data) begin
        log_mismatch($sformatf("core_tx_data[%0d]", i), exp_data, core_tx_data[i]);
      end
      if (core_tx_mask[i] !== exp_mask) begin
        log_mismatch($sformatf("core_tx_mask[%0d]", i), flit_t'(exp_mask),
                     flit_t'(core_tx_mask[i]));
      end
      if (post_tx_ready[i] !== core_tx_ready[i] || user_tx_ready[i] !== core_tx_ready[i]) begin
        log_failure($sformatf("source ready on link %0d does not follow core_tx_ready", i));
      end
    end
  endtask

  // ------------------------------
  // Test phases
  // ------------------------------
  // 16 cycles of reset with checks at the end and just after release
  task automatic apply_reset();
    @(posedge USER_CLK);
    USER_RST       <= 1'b1;
    qpll_lock      <= '1;
    link_init_done <= '0;
    rx_valid       <= '0;
    rx_error       <= '0;
    core_tx_ready  <= '1;
    repeat (RESET_CYCLES - 1) begin
      @(posedge USER_CLK);
      drive_payload();
    end
    @(negedge USER_CLK);
    if (link_soft_reset !== '1) begin
      log_mismatch("link_soft_reset in reset", flit_t'(2'b11), flit_t'(link_soft_reset));
    end
    if (init_done !== 1'b0 || post_ok !== 1'b0 || retry_active !== 1'b0) begin
      log_failure("init_done, post_ok or retry_active not low during reset");
    end
    check_stream(1'b0);
    @(posedge USER_CLK);
    USER_RST <= 1'b0;
    @(negedge USER_CLK);  // Right after release
    if (init_done !== 1'b0 || post_ok !== 1'b0 || retry_active !== 1'b0) begin
      log_failure("init_done, post_ok or retry_active not low after reset release");
    end
  endtask

  task automatic run_retry(input test_row_t row);
    int edges;
    int high;
    edges = 0;
    high  = 0;
    while (retry_active !== 1'b1 && edges <= TIMEOUT_EDGES) begin
      @(posedge USER_CLK);
      @(negedge USER_CLK);
      edges++;
    end
    if (edges != TIMEOUT_EDGES) begin
      log_mismatch("retry_active rise edge", flit_t'(TIMEOUT_EDGES), flit_t'(edges));
    end
    while (retry_active === 1'b1 && high <= RETRY_CYCLES) begin
      if (link_soft_reset !== '1) begin
        log_mismatch("link_soft_reset in retry", flit_t'(2'b11), flit_t'(link_soft_reset));
      end
      high++;
      @(posedge USER_CLK);
      @(negedge USER_CLK);
    end
    if (high != RETRY_CYCLES) begin
      log_mismatch("retry_active high cycles", flit_t'(RETRY_CYCLES), flit_t'(high));
    end
    if (link_soft_reset !== '0) begin
      log_mismatch("link_soft_reset after retry", '0, flit_t'(link_soft_reset));
    end
    if (init_done !== row.exp_init || post_ok !== row.exp_ok) begin
      log_failure("init_done or post_ok set without a completed POST");
    end
  endtask

  task automatic run_post(input test_row_t row);
    link_vec_t exp_rst;
    int        init_edge;
    int        ok_edge;
    exp_rst   = ~row.lock;
    init_edge = 0;
    ok_edge   = 0;
    @(posedge USER_CLK);
    qpll_lock      <= row.lock;
    core_tx_ready  <= row.ready;
    link_init_done <= '1;
    drive_payload();
    @(negedge USER_CLK);
    if (link_soft_reset !== exp_rst) begin  // Same cycle as the lock change
      log_mismatch("link_soft_reset", flit_t'(exp_rst), flit_t'(link_soft_reset));
    end
    check_stream(1'b0);
    for (int f = 0; f < row.nflits; f++) begin
      @(posedge USER_CLK);
      rx_valid <= '1;
      for (int i = 0; i < NL; i++) begin
        rx_error[i] <= (row.err_idx[i] == f);
      end
      drive_payload();
      @(negedge USER_CLK);
      check_stream(1'b0);  // Still on the POST source
    end
    for (int e = 1; e <= OK_LATENCY; e++) begin
      @(posedge USER_CLK);
      rx_valid <= '0;
      rx_error <= '0;
      @(negedge USER_CLK);
      if (init_done === 1'b1 && init_edge == 0) begin
        init_edge = e;
      end
      if (post_ok === 1'b1 && ok_edge == 0) begin
        ok_edge = e;
      end
    end
    if (row.exp_init && init_edge != INIT_LATENCY) begin
      log_mismatch("init_done rise cycle", flit_t'(INIT_LATENCY), flit_t'(init_edge));
    end
    if (row.exp_ok && ok_edge != OK_LATENCY) begin
      log_mismatch("post_ok rise cycle", flit_t'(OK_LATENCY), flit_t'(ok_edge));
    end
    if (init_done !== row.exp_init) begin
      log_mismatch("init_done", flit_t'(row.exp_init), flit_t'(init_done));
    end
    if (post_ok !== row.exp_ok) begin
      log_mismatch("post_ok", flit_t'(row.exp_ok), flit_t'(post_ok));
    end
    @(posedge USER_CLK);
    drive_payload();
    @(negedge USER_CLK);
    check_stream(row.exp_init);  // User source once init is done
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    rng_state      = 32'd28933;
    USER_RST       = 1'b1;
    qpll_lock      = '1;
    link_init_done = '0;
    rx_valid       = '0;
    rx_error       = '0;
    post_tx_valid  = '0;
    post_tx_data   = '0;
    post_tx_mask   = '0;
    user_tx_valid  = '0;
    user_tx_data   = '0;
    user_tx_mask   = '0;
    core_tx_ready  = '1;
    passed         = 0;
    failed         = 0;
    cycles         = 0;

    //      name               flits       err0 err1 lock   ready  init ok
    add_row("post_pass",       POST_FLITS, -1,  -1,  2'b11, 2'b11, 1'b1, 1'b1);
    add_row("post_fail_link1", POST_FLITS, -1,  10,  2'b11, 2'b11, 1'b1, 1'b0);
    add_row("lock_loss_link1", POST_FLITS, -1,  -1,  2'b01, 2'b11, 1'b0, 1'b0);
    add_row("lock_loss_link0", POST_FLITS, -1,  -1,  2'b10, 2'b11, 1'b0, 1'b0);
    add_row("backpressure",    POST_FLITS, -1,  -1,  2'b11, 2'b00, 1'b1, 1'b1);
    add_row("retry_timeout",   0,          -1,  -1,  2'b11, 2'b11, 1'b0, 1'b0);

    cycle_limit = RESET_CYCLES;
    foreach (rows[r]) begin
      cycle_limit += rows[r].nflits + (1 << `HMC_TIMEOUT_BIT) + (1 << `HMC_RETRY_BIT)
                   + 16 + RESET_CYCLES;
    end

    foreach (rows[r]) begin
      cur_name    = rows[r].name;
      test_errors = 0;
      apply_reset();
      if (rows[r].nflits == 0) begin
        run_retry(rows[r]);
      end else begin
        run_post(rows[r]);
      end
      if (test_errors == 0) begin
        $display("Test %s passed", cur_name);
        passed++;
      end else begin
        $display("Test %s failed with %0d errors", cur_name, test_errors);
        failed++;
      end
    end

    $display("Summary: %0d tests, %0d passed, %0d failed", rows.size(), passed, failed);
    if (failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
